// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_data_cache -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_data_cache)"; echo "$$out"; \
		echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+.
mem_op_pkg.sv
cache_pkg.sv
lsu_align.sv
cache_array.sv
cache_ctrl.sv
data_cache_top.sv
tb_data_cache.sv

// ==== cache_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_array (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`SET_BITS-1:0]  set_idx,
    input  wire logic [`TAG_W-1:0]     tag,
    output logic                       hit,
    output logic                       hit_way,
    output cache_pkg::line_t           hit_line,
    output cache_pkg::line_t           victim_line,
    output logic                       victim_way,
    input  wire logic                  fill_en,
    input  wire cache_pkg::line_t      fill_line,
    input  wire logic                  upd_en,
    input  wire logic                  upd_way,
    input  wire cache_pkg::line_t      upd_line
);
    import cache_pkg::*;

    localparam int NSETS = 1 << `SET_BITS;

    line_t            lines [2][NSETS];   // way 0 and way 1
    logic [NSETS-1:0] mru;                // way touched last, per set
    logic             hit0;
    logic             hit1;

    assign hit0 = lines[0][set_idx].valid && (lines[0][set_idx].tag == tag);
    assign hit1 = lines[1][set_idx].valid && (lines[1][set_idx].tag == tag);

    assign hit      = hit0 | hit1;
    assign hit_way  = hit1;
    assign hit_line = lines[hit_way][set_idx];

    // with two ways the victim is simply the other one
    assign victim_way  = ~mru[set_idx];
    assign victim_line = lines[victim_way][set_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NSETS; s++) begin
                lines[0][s].valid <= 1'b0;
                lines[0][s].dirty <= 1'b0;
                lines[1][s].valid <= 1'b0;
                lines[1][s].dirty <= 1'b0;
            end
            mru <= '0;
        end else begin
            // refill lands in the victim, lru untouched until update
            if (fill_en) begin
                lines[victim_way][set_idx] <= fill_line;
            end
            if (upd_en) begin
                lines[upd_way][set_idx] <= upd_line;
                mru[set_idx]            <= upd_way;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module cache_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // core side
    input  wire logic                  cpu_req,
    input  wire mem_op_pkg::cpu_req_t  cpu_req_data,
    output logic                       cpu_ack,
    output mem_op_pkg::cpu_rsp_t       cpu_rsp,
    // memory side
    output logic                       mem_req,
    output cache_pkg::mem_req_t        mem_req_data,
    input  wire logic                  mem_ack,
    input  wire logic [`WORD_W-1:0]    mem_rdata,
    // array
    output logic [`SET_BITS-1:0]       set_idx,
    output logic [`TAG_W-1:0]          tag,
    input  wire logic                  hit,
    input  wire logic                  hit_way,
    input  wire cache_pkg::line_t      hit_line,
    input  wire logic                  victim_way,
    input  wire cache_pkg::line_t      victim_line,
    output logic                       fill_en,
    output cache_pkg::line_t           fill_line,
    output logic                       upd_en,
    output logic                       upd_way,
    output cache_pkg::line_t           upd_line,
    // aligner
    output mem_op_pkg::width_e         al_width,
    output logic [1:0]                 al_offset,
    output logic [`WORD_W-1:0]         al_word,
    output logic [`WORD_W-1:0]         al_store_data,
    input  wire logic [`WORD_W-1:0]    al_load_data,
    input  wire logic [`WORD_W-1:0]    al_merged
);
    import mem_op_pkg::*;
    import cache_pkg::*;

    ctrl_state_e state;
    cpu_req_t    req_q;   // access held from acceptance to ack
    logic        way_q;   // way the access ends up in

    assign set_idx = req_q.addr[`SET_BITS+1:2];
    assign tag     = req_q.addr[`ADDR_W-1:`SET_BITS+2];

    assign al_width      = req_q.width;
    assign al_offset     = req_q.addr[1:0];
    assign al_word       = hit_line.data;   // line always hits by UPDATE
    assign al_store_data = req_q.wdata;

    // refill word written while ack is high
    assign fill_en   = (state == FILL_WAIT) && mem_req && mem_ack;
    assign fill_line = '{valid: 1'b1, dirty: 1'b0, tag: tag, data: mem_rdata};

    assign upd_en   = (state == UPDATE);
    assign upd_way  = way_q;
    assign upd_line = '{valid: 1'b1,
                        dirty: hit_line.dirty | req_q.write,
                        tag:   tag,
                        data:  req_q.write ? al_merged : hit_line.data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= UPDATE;
                    end else if (victim_line.valid && victim_line.dirty) begin
                        state <= WB_REQ;
                    end else begin
                        state <= FILL_REQ;
                    end
                end
                WB_REQ: begin
                    mem_req <= 1'b1;
                    state   <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        state <= FILL_REQ;   // four-phase done
                    end
                end
                FILL_REQ: begin
                    mem_req <= 1'b1;
                    state   <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        state <= UPDATE;
                    end
                end
                UPDATE: begin
                    state <= RESPOND;
                end
                RESPOND: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req) begin
            req_q <= cpu_req_data;
        end
        if (state == LOOKUP) begin
            way_q <= hit ? hit_way : victim_way;
        end
        if (state == WB_REQ) begin
            mem_req_data <= '{write: 1'b1,
                              addr:  {victim_line.tag, set_idx},
                              wdata: victim_line.data};
        end
        if (state == FILL_REQ) begin
            mem_req_data <= '{write: 1'b0, addr: req_q.addr[`ADDR_W-1:2], wdata: '0};
        end
        if (state == UPDATE) begin
            cpu_rsp.rdata <= al_load_data;   // held through RESPOND
        end
    end

endmodule

`default_nettype wire

// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address and data word
`define ADDR_W      32
`define WORD_W      32

// 16 sets, small enough to force conflicts
`define SET_BITS    4

// what is left above set index and byte offset
`define TAG_W       (`ADDR_W - `SET_BITS - 2)

// bound on any wait for a memory handshake, in cycles
`define MEM_TIMEOUT 200

`endif

// ==== cache_pkg.sv ====
`default_nettype none
`include "cache_params.svh"

package cache_pkg;

    // one word per line
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [`TAG_W-1:0] tag;
        logic [`WORD_W-1:0] data;
    } line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,     // raise req for the dirty victim
        WB_WAIT,
        FILL_REQ,   // raise req for the missing word
        FILL_WAIT,
        UPDATE,
        RESPOND
    } ctrl_state_e;

    typedef struct packed {
        logic                 write;
        logic [`ADDR_W-3:0]   addr;   // word address
        logic [`WORD_W-1:0]   wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== data_cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module data_cache_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  cpu_req,
    input  wire mem_op_pkg::cpu_req_t  cpu_req_data,
    output logic                       cpu_ack,
    output mem_op_pkg::cpu_rsp_t       cpu_rsp,
    output logic                       mem_req,
    output cache_pkg::mem_req_t        mem_req_data,
    input  wire logic                  mem_ack,
    input  wire logic [`WORD_W-1:0]    mem_rdata
);
    import mem_op_pkg::*;
    import cache_pkg::*;

    // controller to array
    logic [`SET_BITS-1:0] set_idx;
    logic [`TAG_W-1:0]    tag;
    logic                 hit;
    logic                 hit_way;
    line_t                hit_line;
    logic                 victim_way;
    line_t                victim_line;
    logic                 fill_en;
    line_t                fill_line;
    logic                 upd_en;
    logic                 upd_way;
    line_t                upd_line;

    // controller to aligner
    width_e               al_width;
    logic [1:0]           al_offset;
    logic [`WORD_W-1:0]   al_word;
    logic [`WORD_W-1:0]   al_store_data;
    logic [`WORD_W-1:0]   al_load_data;
    logic [`WORD_W-1:0]   al_merged;

    cache_ctrl u_ctrl (.*);

    cache_array u_array (.*);

    lsu_align u_align (
        .width       (al_width),
        .offset      (al_offset),
        .word_in     (al_word),
        .load_data   (al_load_data),
        .store_data  (al_store_data),
        .merged_word (al_merged)
    );

endmodule

`default_nettype wire

// ==== lsu_align.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module lsu_align (
    input  wire mem_op_pkg::width_e  width,
    input  wire logic [1:0]          offset,
    input  wire logic [`WORD_W-1:0]  word_in,
    output logic [`WORD_W-1:0]       load_data,
    input  wire logic [`WORD_W-1:0]  store_data,
    output logic [`WORD_W-1:0]       merged_word
);
    import mem_op_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        upper_half;

    // misaligned halves fall back to the low half
    assign upper_half = (offset == 2'b10);

    assign ld_byte = word_in[{offset, 3'b000} +: 8];
    assign ld_half = upper_half ? word_in[16 +: 16] : word_in[0 +: 16];

    always_comb begin
        case (width)
            BYTE:    load_data = {{(`WORD_W-8){ld_byte[7]}}, ld_byte};
            HALF:    load_data = {{(`WORD_W-16){ld_half[15]}}, ld_half};
            BYTE_U:  load_data = {{(`WORD_W-8){1'b0}}, ld_byte};
            HALF_U:  load_data = {{(`WORD_W-16){1'b0}}, ld_half};
            default: load_data = word_in;   // LW
        endcase
    end

    // only the addressed bytes change
    always_comb begin
        merged_word = word_in;
        case (width)
            BYTE, BYTE_U: begin
                merged_word[{offset, 3'b000} +: 8] = store_data[7:0];
            end
            HALF, HALF_U: begin
                if (upper_half) begin
                    merged_word[16 +: 16] = store_data[15:0];
                end else begin
                    merged_word[0 +: 16] = store_data[15:0];
                end
            end
            default: begin
                merged_word = store_data;   // SW
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_op_pkg.sv ====
`default_nettype none
`include "cache_params.svh"

package mem_op_pkg;

    // funct3 codes of the RISC-V loads and stores
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,   // loads only
        HALF_U = 3'b101    // loads only
    } width_e;

    typedef struct packed {
        logic               write;
        width_e             width;
        logic [`ADDR_W-1:0] addr;   // byte address
        logic [`WORD_W-1:0] wdata;  // store data, low bytes used
    } cpu_req_t;

    typedef struct packed {
        logic [`WORD_W-1:0] rdata;
    } cpu_rsp_t;

endpackage

`default_nettype wire

// ==== tb_data_cache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cache_params.svh"

module tb_data_cache;
    import mem_op_pkg::*;
    import cache_pkg::*;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cpu_req;
    cpu_req_t           cpu_req_data;
    logic               cpu_ack;
    cpu_rsp_t           cpu_rsp;
    logic               mem_req;
    mem_req_t           mem_req_data;
    logic               mem_ack;
    logic [`WORD_W-1:0] mem_rdata;

    logic [31:0] mem_model [logic [29:0]];   // backing memory
    logic [31:0] shadow [logic [29:0]];      // what the core should read
    logic [31:0] stim_lfsr = 32'h25b8_2e89;
    logic [31:0] mem_lfsr  = 32'h25b8_2e89;
    mem_req_t    last_req;
    mem_req_t    last_wb;
    int          req_count = 0;
    int          wb_count = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic        check_armed = 1'b0;
    logic [31:0] exp_rdata;

    data_cache_top dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    // untouched words read as a pattern of their address
    function automatic logic [31:0] fill_word(input logic [29:0] w);
        return {w, 2'b01} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] w);
        return mem_model.exists(w) ? mem_model[w] : fill_word(w);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [29:0] w);
        return shadow.exists(w) ? shadow[w] : fill_word(w);
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] word, input width_e width,
                                             input logic [1:0] offset);
        logic [31:0] sh;
        sh = word >> (8 * offset);
        case (width)
            BYTE:    return {{24{sh[7]}}, sh[7:0]};
            HALF:    return {{16{sh[15]}}, sh[15:0]};
            BYTE_U:  return {24'h0, sh[7:0]};
            HALF_U:  return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] ref_merge(input logic [31:0] old, input logic [31:0] data,
                                              input width_e width, input logic [1:0] offset);
        logic [31:0] mask;
        case (width)
            BYTE, BYTE_U: mask = 32'h0000_00ff << (8 * offset);
            HALF, HALF_U: mask = 32'h0000_ffff << (8 * offset);
            default:      mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | ((data << (8 * offset)) & mask);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one memory handshake, ack after 0 to 7 idle cycles
    task automatic serve_mem();
        logic [31:0] delay;
        int          t;
        req_count++;
        last_req = mem_req_data;
        if (mem_req_data.write) begin
            mem_model[mem_req_data.addr] = mem_req_data.wdata;
            wb_count++;
            last_wb = mem_req_data;
        end
        take_bits(mem_lfsr, 3, delay);
        repeat (delay) @(posedge clk);
        #1;
        mem_rdata = mem_word(mem_req_data.addr);
        mem_ack = 1'b1;
        t = 0;
        while (mem_req && t < `MEM_TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (mem_req) begin
            $display("timeout: memory request never dropped at %0t", $time);
            timeouts++;
        end
        mem_ack = 1'b0;
    endtask

    always begin
        @(posedge clk);
        if (rst_n && mem_req && !mem_ack) begin
            serve_mem();
        end
    end

    // load data is checked at the ack
    always @(posedge clk) begin
        if (cpu_ack && check_armed) begin
            assert (cpu_rsp.rdata === exp_rdata) else begin
                errors++;
                $display("[FAIL] %0t load of %h returned %h, expected %h", $time,
                         cpu_req_data.addr, cpu_rsp.rdata, exp_rdata);
            end
            check_armed = 1'b0;
        end
    end

    // full four-phase access, lat counts edges from acceptance to ack
    task automatic access(input logic write, input width_e width, input logic [31:0] addr,
                          input logic [31:0] wdata, output int lat);
        logic [29:0] w;
        int          t;
        w = addr[31:2];
        if (write) begin
            shadow[w] = ref_merge(shadow_word(w), wdata, width, addr[1:0]);
        end else begin
            exp_rdata = ref_load(shadow_word(w), width, addr[1:0]);
            check_armed = 1'b1;
        end
        cpu_req_data = '{write: write, width: width, addr: addr, wdata: wdata};
        cpu_req = 1'b1;
        t = 0;
        while (!cpu_ack && t < `MEM_TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        lat = t - 1;
        if (!cpu_ack) begin
            $display("timeout: no ack for access to %h at %0t", addr, $time);
            timeouts++;
        end
        cpu_req = 1'b0;
        t = 0;
        while (cpu_ack && t < `MEM_TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (cpu_ack) begin
            $display("timeout: ack stayed high after access to %h", addr);
            timeouts++;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] rv;
        logic [31:0] data;
        logic [1:0]  off;
        width_e      wd;
        int          lat;
        int          n;
        rst_n = 1'b0;
        cpu_req = 1'b0;
        cpu_req_data = '0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        repeat (2) @(posedge clk);
        #1;
        check_eq(cpu_ack, 0, "cpu_ack in reset");
        check_eq(mem_req, 0, "mem_req in reset");
        rst_n = 1'b1;

        a = 32'h0000_1234;   // first refill
        access(1'b0, WORD, a, 0, lat);
        check_eq(req_count, 1, "requests after first load");
        check_eq({2'b00, last_req.addr}, a >> 2, "refill word address");
        check_eq(last_req.write, 0, "refill is a read");

        a = 32'h0000_2054;
        access(1'b1, WORD, a, 32'h80f1_7f82, lat);
        access(1'b0, WORD, a, 0, lat);
        for (int o = 0; o < 4; o++) begin
            access(1'b0, BYTE, a + o, 0, lat);
            access(1'b0, BYTE_U, a + o, 0, lat);
            if (o % 2 == 0) begin
                access(1'b0, HALF, a + o, 0, lat);
                access(1'b0, HALF_U, a + o, 0, lat);
            end
        end
        for (int o = 0; o < 4; o++) begin
            access(1'b1, BYTE, a + o, 32'hdead_be00 + o, lat);
            access(1'b0, WORD, a, 0, lat);
        end
        access(1'b1, HALF, a, 32'h0bad_c3d2, lat);
        access(1'b0, WORD, a, 0, lat);
        access(1'b1, HALF, a + 2, 32'h0bad_9e17, lat);
        access(1'b0, WORD, a, 0, lat);
        n = req_count;
        access(1'b0, WORD, a, 0, lat);   // repeated hit
        check_eq(lat, 3, "hit latency");
        check_eq(req_count, n, "memory requests on hit");

        // three tags in set 9, the middle one ends up least recent
        access(1'b1, WORD, 32'h0000_3024, 32'h1111_aaaa, lat);
        access(1'b1, WORD, 32'h0000_4024, 32'h2222_bbbb, lat);
        access(1'b0, WORD, 32'h0000_3024, 0, lat);
        n = wb_count;
        access(1'b1, WORD, 32'h0000_5024, 32'h3333_cccc, lat);
        check_eq(wb_count, n + 1, "write-backs on eviction");
        check_eq({2'b00, last_wb.addr}, 32'h0000_4024 >> 2, "write-back address");
        check_eq(last_wb.wdata, 32'h2222_bbbb, "write-back data");
        access(1'b0, WORD, 32'h0000_3024, 0, lat);
        access(1'b0, WORD, 32'h0000_4024, 0, lat);
        access(1'b0, WORD, 32'h0000_5024, 0, lat);

        // random mix over 8 tags in sets 0 to 3
        for (int i = 0; i < 300; i++) begin
            take_bits(stim_lfsr, 11, rv);
            take_bits(stim_lfsr, 32, data);
            case (rv[3:1])
                3'd0, 3'd5: wd = BYTE;
                3'd1, 3'd6: wd = HALF;
                3'd2, 3'd7: wd = WORD;
                3'd3:       wd = rv[0] ? BYTE : BYTE_U;
                default:    wd = rv[0] ? HALF : HALF_U;
            endcase
            off = rv[5:4];
            if (wd == HALF || wd == HALF_U) begin
                off[0] = 1'b0;
            end else if (wd == WORD) begin
                off = 2'b00;
            end
            a = {23'h000040, rv[10:8], 2'b00, rv[7:6], off};
            access(rv[0], wd, a, data, lat);
        end

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
